// ==== common/sa_pkg.sv ====
package sa_pkg;

  // Array shape, overridden from the top level
  localparam int R = 2;
  localparam int C = 2;

  // Element and lane widths
  localparam int WK = 8;
  localparam int WX = 8;
  localparam int WY = 32;

  // Memory and register port widths
  localparam int MEM_W  = 64;
  localparam int ADDR_W = 16;
  localparam int LEN_W  = 16;
  localparam int DATA_W = 32;

  typedef logic [MEM_W-1:0]  mem_word_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // One stream beat, payload in the low bits of the word
  typedef struct packed {
    mem_word_t data;
    logic      last;
    logic      valid;
  } beat_t;

  // Transfer handed to a channel on go
  typedef struct packed {
    addr_t            base;
    logic [LEN_W-1:0] count;
  } job_t;

  // Register word offsets
  typedef enum logic [ADDR_W-1:0] {
    REG_CTRL   = 16'd0,
    REG_STATUS = 16'd1,
    REG_K_ADDR = 16'd2,
    REG_X_ADDR = 16'd3,
    REG_A_ADDR = 16'd4,
    REG_Y_ADDR = 16'd5,
    REG_LEN    = 16'd6
  } reg_addr_e;

  typedef enum logic [1:0] {
    IDLE,
    ACCUM,
    DRAIN
  } sa_state_e;

endpackage

// ==== dma/dma_csr.sv ====
`timescale 1ns/1ps

module dma_csr #(
  parameter int C = sa_pkg::C
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       reg_wr_en,
  input  sa_pkg::addr_t              reg_wr_addr,
  input  logic [sa_pkg::DATA_W-1:0]  reg_wr_data,
  input  logic                       reg_rd_en,
  input  sa_pkg::addr_t              reg_rd_addr,
  output logic [sa_pkg::DATA_W-1:0]  reg_rd_data,

  input  logic                       wr_done,
  output logic                       go,
  output sa_pkg::job_t               k_job,
  output sa_pkg::job_t               x_job,
  output sa_pkg::job_t               a_job,
  output sa_pkg::job_t               y_job,
  output logic                       done
);
  import sa_pkg::*;

  addr_t            k_addr, x_addr, a_addr, y_addr;
  logic [LEN_W-1:0] len;
  logic             busy;
  logic             done_bit;
  logic             start;

  // Start is only honoured while idle
  assign start = reg_wr_en && (reg_wr_addr == REG_CTRL) && reg_wr_data[0] && !busy;

  // Job settings
  always_ff @(posedge clk) begin
    if (reg_wr_en) begin
      case (reg_wr_addr)
        REG_K_ADDR: k_addr <= reg_wr_data[ADDR_W-1:0];
        REG_X_ADDR: x_addr <= reg_wr_data[ADDR_W-1:0];
        REG_A_ADDR: a_addr <= reg_wr_data[ADDR_W-1:0];
        REG_Y_ADDR: y_addr <= reg_wr_data[ADDR_W-1:0];
        REG_LEN:    len    <= reg_wr_data[LEN_W-1:0];
        default: ;
      endcase
    end
  end

  // Job sequencing and status
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      go       <= 1'b0;
      done     <= 1'b0;
      busy     <= 1'b0;
      done_bit <= 1'b0;
    end else begin
      go   <= start;
      done <= busy && wr_done;
      if (start) begin
        busy     <= 1'b1;
        done_bit <= 1'b0;
      end else if (busy && wr_done) begin
        busy     <= 1'b0;
        done_bit <= 1'b1;
      end
    end
  end

  // Operands use LEN beats, bias and result one word per column
  assign k_job = '{base: k_addr, count: len};
  assign x_job = '{base: x_addr, count: len};
  assign a_job = '{base: a_addr, count: LEN_W'(C)};
  assign y_job = '{base: y_addr, count: LEN_W'(C)};

  // Read data lands one cycle after the strobe and holds
  always_ff @(posedge clk) begin
    if (reg_rd_en) begin
      case (reg_rd_addr)
        REG_STATUS: reg_rd_data <= DATA_W'({done_bit, busy});
        REG_K_ADDR: reg_rd_data <= DATA_W'(k_addr);
        REG_X_ADDR: reg_rd_data <= DATA_W'(x_addr);
        REG_A_ADDR: reg_rd_data <= DATA_W'(a_addr);
        REG_Y_ADDR: reg_rd_data <= DATA_W'(y_addr);
        REG_LEN:    reg_rd_data <= DATA_W'(len);
        default:    reg_rd_data <= '0;
      endcase
    end
  end

endmodule

// ==== dma/dma_rd_channel.sv ====
`timescale 1ns/1ps

module dma_rd_channel (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              go,
  input  sa_pkg::job_t      job,

  output logic              rd_en,
  output sa_pkg::addr_t     rd_addr,
  input  sa_pkg::mem_word_t rd_data,
  input  logic              rd_ack,

  output sa_pkg::beat_t     beat,
  input  logic              ready
);
  import sa_pkg::*;

  logic [LEN_W-1:0] remain;
  logic             full;
  logic             fire;
  logic             take;
  mem_word_t        hold_data;
  logic             hold_last;

  assign fire = rd_en && rd_ack;
  assign take = full && ready;

  // Request and holding register control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_en  <= 1'b0;
      full   <= 1'b0;
      remain <= '0;
    end else if (go) begin
      rd_en  <= 1'b0;
      full   <= 1'b0;
      remain <= job.count;
    end else begin
      if (fire) begin
        rd_en  <= 1'b0;
        full   <= 1'b1;
        remain <= remain - 1'b1;
      end else if (take) begin
        full <= 1'b0;
      end
      // New request only once the slot is free or draining now
      if (!rd_en && (remain != '0) && (!full || take))
        rd_en <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      rd_addr <= job.base;
    end else if (fire) begin
      rd_addr   <= rd_addr + 1'b1;
      hold_data <= rd_data;
      hold_last <= (remain == LEN_W'(1));
    end
  end

  assign beat = '{data: hold_data, last: hold_last, valid: full};

endmodule

// ==== dma/dma_wr_channel.sv ====
`timescale 1ns/1ps

module dma_wr_channel (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              go,
  input  sa_pkg::job_t      job,

  input  sa_pkg::beat_t     beat,
  output logic              ready,

  output logic              wr_en,
  output sa_pkg::addr_t     wr_addr,
  output sa_pkg::mem_word_t wr_data,
  input  logic              wr_ack,
  output logic              wr_done
);
  import sa_pkg::*;

  logic [LEN_W-1:0] remain;
  logic             accept;
  logic             wr_last;

  // One write in flight, no new beat until it is acked
  assign ready  = (remain != '0) && !wr_en;
  assign accept = beat.valid && ready;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_en  <= 1'b0;
      remain <= '0;
    end else if (go) begin
      wr_en  <= 1'b0;
      remain <= job.count;
    end else if (accept) begin
      wr_en  <= 1'b1;
      remain <= remain - 1'b1;
    end else if (wr_ack) begin
      wr_en <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      wr_addr <= job.base;
    end else if (accept) begin
      wr_data <= beat.data;
      wr_last <= beat.last;
    end else if (wr_en && wr_ack) begin
      wr_addr <= wr_addr + 1'b1;
    end
  end

  assign wr_done = wr_en && wr_ack && wr_last;

endmodule

// ==== hdl/sa_accel_top.sv ====
`timescale 1ns/1ps

module sa_accel_top #(
  parameter int R = sa_pkg::R,
  parameter int C = sa_pkg::C
) (
  input  logic                       clk,
  input  logic                       rst_n,

  input  logic                       reg_wr_en,
  input  sa_pkg::addr_t              reg_wr_addr,
  input  logic [sa_pkg::DATA_W-1:0]  reg_wr_data,
  input  logic                       reg_rd_en,
  input  sa_pkg::addr_t              reg_rd_addr,
  output logic [sa_pkg::DATA_W-1:0]  reg_rd_data,
  output logic                       done,

  output logic                       k_rd_en,
  output sa_pkg::addr_t              k_rd_addr,
  input  sa_pkg::mem_word_t          k_rd_data,
  input  logic                       k_rd_ack,

  output logic                       x_rd_en,
  output sa_pkg::addr_t              x_rd_addr,
  input  sa_pkg::mem_word_t          x_rd_data,
  input  logic                       x_rd_ack,

  output logic                       a_rd_en,
  output sa_pkg::addr_t              a_rd_addr,
  input  sa_pkg::mem_word_t          a_rd_data,
  input  logic                       a_rd_ack,

  output logic                       y_wr_en,
  output sa_pkg::addr_t              y_wr_addr,
  output sa_pkg::mem_word_t          y_wr_data,
  input  logic                       y_wr_ack
);
  import sa_pkg::*;

  logic  go;
  logic  wr_done;
  job_t  k_job, x_job, a_job, y_job;

  beat_t k_beat, x_beat, a_beat, y_beat;
  logic  k_ready, x_ready, a_ready, y_ready;

  dma_csr #(.C(C)) CSR (
    .clk, .rst_n,
    .reg_wr_en, .reg_wr_addr, .reg_wr_data,
    .reg_rd_en, .reg_rd_addr, .reg_rd_data,
    .wr_done,
    .go,
    .k_job, .x_job, .a_job, .y_job,
    .done
  );

  // One read channel per operand stream
  dma_rd_channel K_RD (
    .clk, .rst_n, .go, .job(k_job),
    .rd_en(k_rd_en), .rd_addr(k_rd_addr), .rd_data(k_rd_data), .rd_ack(k_rd_ack),
    .beat(k_beat), .ready(k_ready)
  );

  dma_rd_channel X_RD (
    .clk, .rst_n, .go, .job(x_job),
    .rd_en(x_rd_en), .rd_addr(x_rd_addr), .rd_data(x_rd_data), .rd_ack(x_rd_ack),
    .beat(x_beat), .ready(x_ready)
  );

  dma_rd_channel A_RD (
    .clk, .rst_n, .go, .job(a_job),
    .rd_en(a_rd_en), .rd_addr(a_rd_addr), .rd_data(a_rd_data), .rd_ack(a_rd_ack),
    .beat(a_beat), .ready(a_ready)
  );

  sa_core #(.R(R), .C(C)) CORE (
    .clk, .rst_n,
    .k_beat, .k_ready,
    .x_beat, .x_ready,
    .a_beat, .a_ready,
    .y_beat, .y_ready
  );

  dma_wr_channel Y_WR (
    .clk, .rst_n, .go, .job(y_job),
    .beat(y_beat), .ready(y_ready),
    .wr_en(y_wr_en), .wr_addr(y_wr_addr), .wr_data(y_wr_data), .wr_ack(y_wr_ack),
    .wr_done
  );

endmodule

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and pass only if the testbench reports a pass
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f \
  && out=$(./obj_dir/Vtb_top) \
  || { echo "build or simulation did not complete"; exit 1; }
echo "$out"
echo "$out" | grep -qx "PASS: all tests" && exit 0 || exit 1

// ==== sa/sa_core.sv ====
`timescale 1ns/1ps

module sa_core #(
  parameter int R = sa_pkg::R,
  parameter int C = sa_pkg::C
) (
  input  logic          clk,
  input  logic          rst_n,

  input  sa_pkg::beat_t k_beat,
  output logic          k_ready,
  input  sa_pkg::beat_t x_beat,
  output logic          x_ready,
  input  sa_pkg::beat_t a_beat,
  output logic          a_ready,

  output sa_pkg::beat_t y_beat,
  input  logic          y_ready
);
  import sa_pkg::*;

  localparam int CW = (C > 1) ? $clog2(C) : 1;

  sa_state_e            state;
  logic [CW-1:0]        col;
  logic                 in_ok;
  logic                 join_fire;
  logic                 join_last;
  logic                 y_fire;
  logic                 y_last;
  mem_word_t            y_data;

  logic signed [WX-1:0]    x_el [R];
  logic signed [WK-1:0]    k_el [C];
  logic signed [WX+WK-1:0] prod [R][C];
  logic signed [WY-1:0]    grid [R][C];

  // k/x join, both streams move together
  assign in_ok     = (state != DRAIN);
  assign k_ready   = in_ok && x_beat.valid;
  assign x_ready   = in_ok && k_beat.valid;
  assign join_fire = in_ok && k_beat.valid && x_beat.valid;
  assign join_last = k_beat.last && x_beat.last;

  for (genvar r = 0; r < R; r++) begin : g_row
    assign x_el[r] = x_beat.data[r*WX +: WX];
    for (genvar c = 0; c < C; c++) begin : g_col
      assign prod[r][c] = x_el[r] * k_el[c];
    end
  end

  for (genvar c = 0; c < C; c++) begin : g_kel
    assign k_el[c] = k_beat.data[c*WK +: WK];
  end

  // Outer product accumulation, cleared after the last output word
  always_ff @(posedge clk) begin
    if (!rst_n || (y_fire && y_last)) begin
      for (int r = 0; r < R; r++) begin
        for (int c = 0; c < C; c++) begin
          grid[r][c] <= '0;
        end
      end
    end else if (join_fire) begin
      for (int r = 0; r < R; r++) begin
        for (int c = 0; c < C; c++) begin
          grid[r][c] <= grid[r][c] + prod[r][c];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      col   <= '0;
    end else begin
      case (state)
        IDLE, ACCUM: begin
          if (join_fire)
            state <= join_last ? DRAIN : ACCUM;
        end
        DRAIN: begin
          if (y_fire) begin
            col <= y_last ? '0 : col + 1'b1;
            if (y_last)
              state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Drain one column per word, bias word c pairs with output word c
  assign y_last  = (col == CW'(C - 1));
  assign a_ready = (state == DRAIN) && y_ready;
  assign y_fire  = (state == DRAIN) && a_beat.valid && y_ready;

  always_comb begin
    y_data = '0;
    for (int r = 0; r < R; r++) begin
      y_data[r*WY +: WY] = grid[r][col] + a_beat.data[r*WY +: WY];
    end
  end

  assign y_beat = '{data: y_data, last: y_last, valid: (state == DRAIN) && a_beat.valid};

endmodule

// ==== tb.f ====
common/sa_pkg.sv
dma/dma_csr.sv
dma/dma_rd_channel.sv
dma/dma_wr_channel.sv
sa/sa_core.sv
hdl/sa_accel_top.sv
tests/tb_clk.sv
tests/tb_mem.sv
tests/tb_top.sv

// ==== tests/tb_clk.sv ====
`timescale 1ns/1ps

module tb_clk #(
  parameter int PERIOD_NS = 20
) (
  output logic clk
);

  initial clk = 1'b0;

  always #(PERIOD_NS / 2) clk = ~clk;

endmodule

// ==== tests/tb_mem.sv ====
`timescale 1ns/1ps

module tb_mem (
  input  logic              clk,
  input  logic              load_en,
  input  sa_pkg::addr_t     load_addr,
  input  sa_pkg::mem_word_t load_data,
  input  logic              k_rd_en,
  input  sa_pkg::addr_t     k_rd_addr,
  output sa_pkg::mem_word_t k_rd_data,
  output logic              k_rd_ack,
  input  logic              x_rd_en,
  input  sa_pkg::addr_t     x_rd_addr,
  output sa_pkg::mem_word_t x_rd_data,
  output logic              x_rd_ack,
  input  logic              a_rd_en,
  input  sa_pkg::addr_t     a_rd_addr,
  output sa_pkg::mem_word_t a_rd_data,
  output logic              a_rd_ack,
  input  logic              y_wr_en,
  input  sa_pkg::addr_t     y_wr_addr,
  input  sa_pkg::mem_word_t y_wr_data,
  output logic              y_wr_ack
);
  import sa_pkg::*;

  mem_word_t   mem [256];
  mem_word_t   rd_data [4];
  logic [3:0]  en;
  addr_t       addr [4];
  logic [3:0]  ack = '0;
  logic [3:0]  started = '0;
  logic [1:0]  cnt [4];
  logic [1:0]  gap;
  logic [15:0] lfsr = 16'd25;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  // Ports 0..2 read k, x, a; port 3 writes y
  assign en   = {y_wr_en, a_rd_en, x_rd_en, k_rd_en};
  assign addr = '{k_rd_addr, x_rd_addr, a_rd_addr, y_wr_addr};
  assign k_rd_data = rd_data[0];
  assign x_rd_data = rd_data[1];
  assign a_rd_data = rd_data[2];
  assign {y_wr_ack, a_rd_ack, x_rd_ack, k_rd_ack} = ack;

  always @(posedge clk) begin
    if (load_en)
      mem[load_addr[7:0]] <= load_data;
    for (int p = 0; p < 4; p++) begin
      if (ack[p]) begin
        ack[p]     <= 1'b0;
        started[p] <= 1'b0;
      end else if (en[p]) begin
        // Draw a new delay of 1 to 4 cycles on the first cycle of a request
        if (!started[p]) begin
          lfsr = lfsr_next(lfsr);
          gap[0] = lfsr[0];
          lfsr = lfsr_next(lfsr);
          gap[1] = lfsr[0];
          started[p] <= 1'b1;
        end else begin
          gap = cnt[p];
        end
        if (gap == 2'd0) begin
          ack[p] <= 1'b1;
          if (p == 3)
            mem[addr[p][7:0]] <= y_wr_data;
          else
            rd_data[p] <= mem[addr[p][7:0]];
        end else begin
          cnt[p] <= gap - 2'd1;
        end
      end
    end
  end

endmodule

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;
  import sa_pkg::*;

  localparam int R = 2;
  localparam int C = 2;
  // k, x, a and y beats of every job in the run
  localparam int TOTAL_BEATS = 2 * (1 + 8 + 8 + 5) + 4 * 2 * C;
  localparam int WATCHDOG_CYCLES = 200 * TOTAL_BEATS;

  logic              clk, rst_n, done;
  logic              reg_wr_en, reg_rd_en, load_en;
  addr_t             reg_wr_addr, reg_rd_addr, load_addr;
  logic [DATA_W-1:0] reg_wr_data, reg_rd_data;
  logic              k_rd_en, x_rd_en, a_rd_en, y_wr_en;
  logic              k_rd_ack, x_rd_ack, a_rd_ack, y_wr_ack;
  addr_t             k_rd_addr, x_rd_addr, a_rd_addr, y_wr_addr;
  mem_word_t         k_rd_data, x_rd_data, a_rd_data, y_wr_data, load_data;

  logic [3:0]  req, ack;
  addr_t       req_addr [4];
  addr_t       lo [4];
  addr_t       hi [4];
  int          sva_errors = 0;
  int          chk_errors = 0;
  int          done_seen = 0;
  int          tests = 0;
  int          failed = 0;
  logic [15:0] lfsr = 16'd25;

  tb_clk #(.PERIOD_NS(20)) CLK (.clk);
  sa_accel_top #(.R(R), .C(C)) DUT (.*);
  tb_mem MEM (.*);

  assign req      = {y_wr_en, a_rd_en, x_rd_en, k_rd_en};
  assign ack      = {y_wr_ack, a_rd_ack, x_rd_ack, k_rd_ack};
  assign req_addr = '{k_rd_addr, x_rd_addr, a_rd_addr, y_wr_addr};

  always @(posedge clk) begin
    if (rst_n && done)
      done_seen <= done_seen + 1;
  end

  for (genvar p = 0; p < 4; p++) begin : g_port
    assert property (@(posedge clk) disable iff (!rst_n)
        req[p] |-> (req_addr[p] >= lo[p]) && (req_addr[p] < hi[p]))
      else begin
        sva_errors++;
        $display("Port %0d requested address %h outside its job range", p, req_addr[p]);
      end
    // A pending request keeps its address until the ack
    assert property (@(posedge clk) disable iff (!rst_n)
        $past(req[p]) && !$past(ack[p]) |-> req[p] && $stable(req_addr[p]))
      else begin
        sva_errors++;
        $display("Port %0d changed or dropped its request before the ack", p);
      end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
      $past(y_wr_en) && !$past(y_wr_ack) |-> $stable(y_wr_data))
    else begin
      sva_errors++;
      $display("Write data changed while the write was pending");
    end

  assert property (@(posedge clk) disable iff (!rst_n) $past(done) |-> !done)
    else begin
      sva_errors++;
      $display("done stayed high for more than one cycle");
    end

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
  endfunction

  task automatic draw_word(output mem_word_t w);
    for (int i = 0; i < MEM_W; i++) begin
      lfsr = lfsr_next(lfsr);
      w[i] = lfsr[0];
    end
  endtask

  task automatic reg_write(input addr_t addr, input logic [DATA_W-1:0] data);
    @(posedge clk);
    reg_wr_en   <= 1'b1;
    reg_wr_addr <= addr;
    reg_wr_data <= data;
    @(posedge clk);
    reg_wr_en <= 1'b0;
  endtask

  task automatic reg_read(input addr_t addr, output logic [DATA_W-1:0] data);
    @(posedge clk);
    reg_rd_en   <= 1'b1;
    reg_rd_addr <= addr;
    @(posedge clk);
    reg_rd_en <= 1'b0;
    @(negedge clk);
    data = reg_rd_data;
  endtask

  task automatic mem_load(input addr_t addr, input mem_word_t data);
    @(posedge clk);
    load_en   <= 1'b1;
    load_addr <= addr;
    load_data <= data;
  endtask

  task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act == exp)
      else begin
        chk_errors++;
        $display("** Error %s: expected %h, actual %h", name, exp, act);
      end
  endtask

  task automatic report(input string name, input int e0);
    int n;
    n = chk_errors + sva_errors - e0;
    tests++;
    if (n != 0)
      failed++;
    $display("test %-20s %s (%0d errors)", name, (n == 0) ? "ok" : "failed", n);
  endtask

  // mid: 0 nothing, 1 read busy during the job, 2 write start during the job
  task automatic run_job(input string name, input addr_t kb, xb, ab, yb,
                         input int len, input bit known, input int mid);
    mem_word_t            kw [8];
    mem_word_t            xw [8];
    mem_word_t            aw [C];
    mem_word_t            exp_w;
    logic [DATA_W-1:0]    status;
    logic signed [WY-1:0] lane;
    logic signed [WX-1:0] xe;
    logic signed [WK-1:0] ke;
    int                   done_before;
    lo = '{kb, xb, ab, yb};
    hi = '{addr_t'(kb + len), addr_t'(xb + len), addr_t'(ab + C), addr_t'(yb + C)};
    for (int i = 0; i < len; i++) begin
      if (known) begin
        kw[i] = 64'h05FD;
        xw[i] = 64'hF907;
      end else begin
        draw_word(kw[i]);
        draw_word(xw[i]);
      end
      mem_load(addr_t'(kb + i), kw[i]);
      mem_load(addr_t'(xb + i), xw[i]);
    end
    for (int c = 0; c < C; c++) begin
      if (known)
        aw[c] = {32'(100 * c + 101), 32'(100 * c + 100)};
      else
        draw_word(aw[c]);
      mem_load(addr_t'(ab + c), aw[c]);
    end
    @(posedge clk);
    load_en <= 1'b0;
    reg_write(REG_K_ADDR, DATA_W'(kb));
    reg_write(REG_X_ADDR, DATA_W'(xb));
    reg_write(REG_A_ADDR, DATA_W'(ab));
    reg_write(REG_Y_ADDR, DATA_W'(yb));
    reg_write(REG_LEN, DATA_W'(len));
    done_before = done_seen;
    reg_write(REG_CTRL, 32'd1);
    if (mid == 1) begin
      reg_read(REG_STATUS, status);
      check({name, " busy"}, 64'd1, 64'(status));
    end else if (mid == 2) begin
      repeat (3) @(posedge clk);
      reg_write(REG_CTRL, 32'd1);
    end
    for (int n = 0; n < 200 * (2 * len + 2 * C) && !done; n++)
      @(negedge clk);
    if (!done) begin
      chk_errors++;
      $display("%s: no done pulse within the job's time limit", name);
    end
    repeat (20) @(negedge clk);
    check({name, " done pulses"}, 64'd1, 64'(done_seen - done_before));
    reg_read(REG_STATUS, status);
    check({name, " status"}, 64'd2, 64'(status));
    // Word c, lane r: sum of x[r]*k[c] over the beats plus lane r of bias word c
    for (int c = 0; c < C; c++) begin
      exp_w = '0;
      for (int r = 0; r < R; r++) begin
        lane = aw[c][r*WY +: WY];
        for (int i = 0; i < len; i++) begin
          xe = xw[i][r*WX +: WX];
          ke = kw[i][c*WK +: WK];
          lane = lane + WY'(xe) * WY'(ke);
        end
        exp_w[r*WY +: WY] = lane;
      end
      check($sformatf("%s y[%0d]", name, c), exp_w, MEM.mem[8'(yb + c)]);
    end
  endtask

  initial begin
    logic [DATA_W-1:0] rd;
    int                e0;
    rst_n       <= 1'b0;
    reg_wr_en   <= 1'b0;
    reg_wr_addr <= '0;
    reg_wr_data <= '0;
    reg_rd_en   <= 1'b0;
    reg_rd_addr <= '0;
    load_en     <= 1'b0;
    load_addr   <= '0;
    load_data   <= '0;
    lo = '{default: '0};
    hi = '{default: '0};
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    e0 = chk_errors + sva_errors;
    @(negedge clk);
    check("reset outputs", 64'd0, 64'({done, k_rd_en, x_rd_en, a_rd_en, y_wr_en}));
    reg_read(REG_STATUS, rd);
    check("reset status", 64'd0, 64'(rd));
    report("reset", e0);

    e0 = chk_errors + sva_errors;
    for (int pass = 0; pass < 2; pass++) begin
      for (int i = 2; i <= 6; i++)
        reg_write(addr_t'(i), DATA_W'(16'h0A00 + 16'h0111 * i + 16'h1000 * pass));
    end
    for (int i = 2; i <= 6; i++) begin
      reg_read(addr_t'(i), rd);
      check($sformatf("register %0d", i), 64'(16'h1A00 + 16'h0111 * i), 64'(rd));
    end
    reg_read(addr_t'(9), rd);
    check("unmapped register", 64'd0, 64'(rd));
    report("register readback", e0);

    e0 = chk_errors + sva_errors;
    run_job("single beat", 16'h10, 16'h20, 16'h30, 16'h40, 1, 1'b1, 0);
    report("single beat", e0);

    e0 = chk_errors + sva_errors;
    run_job("eight beats", 16'h50, 16'h60, 16'h70, 16'h78, 8, 1'b0, 1);
    report("eight beats", e0);

    e0 = chk_errors + sva_errors;
    run_job("start while busy", 16'h80, 16'h90, 16'hA0, 16'hA8, 8, 1'b0, 2);
    run_job("second job", 16'hB0, 16'hC0, 16'hD0, 16'hD8, 5, 1'b0, 0);
    report("start while busy", e0);

    $display("%0d tests, %0d failed, %0d errors", tests, failed, chk_errors + sva_errors);
    if (chk_errors + sva_errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule
